// File: Makefile
TOP = tb_aux_tx

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run:
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: filelist.f
src/aux_pkg.sv
src/aux_fifo.sv
src/aux_lb_regs.sv
src/aux_tx_encoder.sv
src/aux_tx_top.sv
testbench/aux_tx_checker.sv
testbench/tb_aux_tx.sv

// File: src/aux_fifo.sv
`timescale 1ns/10ps

module aux_fifo
#(
	parameter FIFO_WORDS = 32,
	localparam ADR_WIDTH = $clog2(FIFO_WORDS)
)
(
	input wire					CLK_IN,
	input wire					RST_IN,
	input wire					clr,		// Flush all entries
	input wire					wr,
	input wire [aux_pkg::TX_WORD_WIDTH-1:0]		din,
	input wire					rd,
	output logic [aux_pkg::TX_WORD_WIDTH-1:0]	dout,		// Oldest entry
	output logic					de,		// dout valid
	output logic [ADR_WIDTH:0]			wrds,		// Used words
	output logic					ep,
	output logic					fl
);

logic [aux_pkg::TX_WORD_WIDTH-1:0]	mem [FIFO_WORDS];
logic [ADR_WIDTH-1:0]			wp;
logic [ADR_WIDTH-1:0]			rp;
logic [ADR_WIDTH:0]			cnt;
logic					wr_ok;
logic					rd_ok;

	assign wr_ok = wr && !fl;	// Write when full is dropped
	assign rd_ok = rd && de;

// Pointers and word counter
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
		end
		else if (clr)
		begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
		end
		else
		begin
			if (wr_ok)
				wp <= wp + 1'b1;	// Wraps at power of two
			if (rd_ok)
				rp <= rp + 1'b1;

			if (wr_ok && !rd_ok)
				cnt <= cnt + 1'b1;
			else if (rd_ok && !wr_ok)
				cnt <= cnt - 1'b1;
		end
	end

// Storage
	always_ff @ (posedge CLK_IN)
	begin
		if (wr_ok)
			mem[wp] <= din;
	end

	assign dout = mem[rp];		// First word falls through
	assign ep = (cnt == '0);
	assign fl = (cnt == FIFO_WORDS);
	assign de = !ep;
	assign wrds = cnt;

	// Encoder must not pop an empty FIFO
	a_no_rd_empty : assert property (@(posedge CLK_IN) disable iff (RST_IN) rd |-> !ep)
		else $error("aux_fifo read while empty");

	a_cnt_bound : assert property (@(posedge CLK_IN) disable iff (RST_IN) wrds <= FIFO_WORDS)
		else $error("aux_fifo word count above depth");

endmodule

// File: src/aux_lb_regs.sv
`timescale 1ns/10ps

module aux_lb_regs
(
	input wire					CLK_IN,
	input wire					RST_IN,
	input aux_pkg::lb_adr_t				lb_adr,
	input wire					lb_wr,
	input wire					lb_rd,
	input wire [aux_pkg::LB_DAT_WIDTH-1:0]		lb_din,
	output logic [aux_pkg::LB_DAT_WIDTH-1:0]	lb_dout,
	output logic					lb_vld,
	output logic					run,
	output logic					msg_send,
	output logic					tst,
	input wire					msg_send_clr,	// From encoder
	input wire					msg_done_set,	// From encoder
	input wire					fifo_ep,
	input wire					fifo_fl,
	output logic					fifo_wr,
	output logic [aux_pkg::TX_WORD_WIDTH-1:0]	fifo_din,
	output logic					fifo_clr,
	output logic					irq
);

aux_pkg::lb_adr_t			adr_q;
logic					wr_q;
logic					rd_q;
logic [aux_pkg::LB_DAT_WIDTH-1:0]	din_q;
logic [aux_pkg::CTL_WIDTH-1:0]		ctl_r;
logic [aux_pkg::STA_WIDTH-1:0]		sta_r;
logic					ctl_wr;
logic					sta_wr;
logic					ie;
logic					msg_done;

// Bus strobes
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			wr_q <= 1'b0;
			rd_q <= 1'b0;
		end
		else
		begin
			wr_q <= lb_wr;
			rd_q <= lb_rd;
		end
	end

// Bus address and data
	always_ff @ (posedge CLK_IN)
	begin
		adr_q <= lb_adr;
		din_q <= lb_din;
	end

	// Address decode
	assign ctl_wr = wr_q && (adr_q == aux_pkg::adr_ctl);
	assign sta_wr = wr_q && (adr_q == aux_pkg::adr_sta);
	assign fifo_wr = wr_q && (adr_q == aux_pkg::adr_tx_fifo);
	assign fifo_din = din_q[aux_pkg::TX_WORD_WIDTH-1:0];	// Token bit plus byte

// Control register
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			ctl_r <= '0;
		else if (ctl_wr)
			ctl_r <= din_q[aux_pkg::CTL_WIDTH-1:0];
		else if (msg_send_clr)
			ctl_r[aux_pkg::CTL_MSG_SEND] <= 1'b0;	// Encoder took the message
	end

	assign run = ctl_r[aux_pkg::CTL_RUN];
	assign ie = ctl_r[aux_pkg::CTL_IE];
	assign msg_send = ctl_r[aux_pkg::CTL_MSG_SEND];
	assign tst = ctl_r[aux_pkg::CTL_TST];

// Sticky flags, write 1 to clear
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			msg_done <= 1'b0;
			irq <= 1'b0;
		end
		else if (!run)
		begin
			msg_done <= 1'b0;
			irq <= 1'b0;
		end
		else
		begin
			if (msg_done_set)
				msg_done <= 1'b1;
			else if (sta_wr && din_q[aux_pkg::STA_MSG_DONE])
				msg_done <= 1'b0;

			// Only message done can interrupt
			if (ie && msg_done_set)
				irq <= 1'b1;
			else if (sta_wr && din_q[aux_pkg::STA_IRQ])
				irq <= 1'b0;
		end
	end

// FIFO flush follows run
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			fifo_clr <= 1'b1;
		else
			fifo_clr <= !run;
	end

// Status word
	always_comb
	begin
		sta_r = '0;
		sta_r[aux_pkg::STA_IRQ] = irq;
		sta_r[aux_pkg::STA_MSG_DONE] = msg_done;
		sta_r[aux_pkg::STA_TX_FIFO_EP] = fifo_ep;
		sta_r[aux_pkg::STA_TX_FIFO_FL] = fifo_fl;
	end

// Read mux
	always_comb
	begin
		lb_dout = '0;
		case (adr_q)
			aux_pkg::adr_ctl :
				lb_dout[aux_pkg::CTL_WIDTH-1:0] = ctl_r;
			aux_pkg::adr_sta :
				lb_dout[aux_pkg::STA_WIDTH-1:0] = sta_r;
			default :
				lb_dout = aux_pkg::LB_DOUT_DEFAULT;	// TX FIFO and RX slot
		endcase
	end

	assign lb_vld = rd_q;		// One clock after the read strobe

	// Interrupt needs IE in the cycle the encoder reports done
	a_irq_ie : assert property (@(posedge CLK_IN) disable iff (RST_IN) $rose(irq) |-> $past(ie))
		else $error("aux_lb_regs irq raised with IE clear");

endmodule

// File: src/aux_pkg.sv
package aux_pkg;

	// Local bus
	localparam LB_ADR_WIDTH = 2;
	localparam LB_DAT_WIDTH = 32;
	localparam logic [LB_DAT_WIDTH-1:0] LB_DOUT_DEFAULT = 32'hdeadcafe;	// Unmapped or empty slot

	typedef enum logic [LB_ADR_WIDTH-1:0] {
		adr_ctl		= 2'd0,
		adr_sta		= 2'd1,
		adr_tx_fifo	= 2'd2,
		adr_rx_fifo	= 2'd3		// No receiver, default pattern only
	} lb_adr_t;

	// Control register, bit 3 reserved
	localparam CTL_WIDTH		= 5;
	localparam CTL_RUN		= 0;
	localparam CTL_IE		= 1;
	localparam CTL_MSG_SEND		= 2;
	localparam CTL_TST		= 4;	// Line toggles with beat

	// Status register
	localparam STA_WIDTH		= 16;
	localparam STA_IRQ		= 0;
	localparam STA_MSG_DONE		= 1;
	localparam STA_TX_FIFO_EP	= 5;
	localparam STA_TX_FIFO_FL	= 6;

	// TX data path
	localparam BYTE_WIDTH		= 8;
	localparam TX_WORD_WIDTH	= 9;
	localparam TX_TOKEN_BIT		= 8;	// Set means stop token

	typedef enum logic [3:0] {
		st_idle, st_en, st_run, st_re, st_fe,
		st_stp1, st_stp2, st_stp3, st_stp4,
		st_tst1, st_tst2
	} tx_state_t;

endpackage

// File: src/aux_tx_encoder.sv
`timescale 1ns/10ps

module aux_tx_encoder
(
	input wire					CLK_IN,
	input wire					RST_IN,
	input wire					BEAT_IN,	// Half-bit strobe
	input wire					run,
	input wire					msg_send,
	input wire					tst,
	input wire [aux_pkg::TX_WORD_WIDTH-1:0]		fifo_dout,
	input wire					fifo_de,
	input wire					fifo_ep,
	output logic					fifo_rd,
	output logic					msg_send_clr,
	output logic					msg_done_set,
	output logic					aux_en,
	output logic					aux_tx
);

localparam CNT_WIDTH = $clog2(aux_pkg::BYTE_WIDTH);

aux_pkg::tx_state_t			st_cur;
aux_pkg::tx_state_t			st_nxt;
logic [1:0]				beat_sr;	// Sampled beat, newest in bit 0
logic					beat_re;
logic					beat_fe;
logic [aux_pkg::BYTE_WIDTH-1:0]		shft;
logic [CNT_WIDTH-1:0]			shft_cnt;
logic					shft_ld;
logic					shft_nxt;
logic					shft_out;
logic					shft_end;
logic					en_set;
logic					en_clr;
logic					tx_set;
logic					tx_clr;

// Beat edge detector
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			beat_sr <= 2'b00;
			beat_re <= 1'b0;
			beat_fe <= 1'b0;
		end
		else
		begin
			if (run)
				beat_sr <= {beat_sr[0], BEAT_IN};
			beat_re <= run && beat_sr[0] && !beat_sr[1];
			beat_fe <= run && !beat_sr[0] && beat_sr[1];
		end
	end

// State register
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			st_cur <= aux_pkg::st_idle;
		else if (run)
			st_cur <= st_nxt;
		else
			st_cur <= aux_pkg::st_idle;
	end

// Next state and strobes
	always_comb
	begin
		st_nxt = st_cur;	// Hold by default
		en_set = 1'b0;
		en_clr = 1'b0;
		tx_set = 1'b0;
		tx_clr = 1'b0;
		shft_ld = 1'b0;
		shft_nxt = 1'b0;
		fifo_rd = 1'b0;
		msg_send_clr = 1'b0;
		msg_done_set = 1'b0;

		case (st_cur)
			aux_pkg::st_idle :
			begin
				if (tst)
				begin
					en_set = 1'b1;		// Test drives at once
					st_nxt = aux_pkg::st_tst1;
				end
				else if (msg_send)
				begin
					msg_send_clr = 1'b1;
					st_nxt = aux_pkg::st_en;
				end
			end

			aux_pkg::st_en :
				if (beat_fe)
				begin
					en_set = 1'b1;
					st_nxt = aux_pkg::st_run;
				end

			aux_pkg::st_run :
			begin
				if (fifo_de)
				begin
					fifo_rd = 1'b1;
					if (fifo_dout[aux_pkg::TX_TOKEN_BIT])
						st_nxt = aux_pkg::st_stp1;
					else
					begin
						shft_ld = 1'b1;
						st_nxt = aux_pkg::st_re;
					end
				end
				else if (fifo_ep && beat_re)
				begin
					// Message over, release the line
					en_clr = 1'b1;
					tx_clr = 1'b1;
					msg_done_set = 1'b1;
					st_nxt = aux_pkg::st_idle;
				end
			end

			// First half of the bit cell
			aux_pkg::st_re :
				if (beat_re)
				begin
					tx_set = shft_out;
					tx_clr = !shft_out;
					st_nxt = aux_pkg::st_fe;
				end

			// Second half, inverted
			aux_pkg::st_fe :
				if (beat_fe)
				begin
					tx_set = !shft_out;
					tx_clr = shft_out;
					if (shft_end)
						st_nxt = aux_pkg::st_run;
					else
					begin
						shft_nxt = 1'b1;
						st_nxt = aux_pkg::st_re;
					end
				end

			// Stop token, two beats high
			aux_pkg::st_stp1 :
				if (beat_re)
				begin
					tx_set = 1'b1;
					st_nxt = aux_pkg::st_stp2;
				end

			aux_pkg::st_stp2 :
				if (beat_re)
					st_nxt = aux_pkg::st_stp3;

			// Then two beats low
			aux_pkg::st_stp3 :
				if (beat_re)
				begin
					tx_clr = 1'b1;
					st_nxt = aux_pkg::st_stp4;
				end

			aux_pkg::st_stp4 :
				if (beat_re)
					st_nxt = aux_pkg::st_run;

			aux_pkg::st_tst1 :
				if (!tst)
				begin
					en_clr = 1'b1;
					tx_clr = 1'b1;
					st_nxt = aux_pkg::st_idle;
				end
				else if (beat_re)
				begin
					tx_set = 1'b1;
					st_nxt = aux_pkg::st_tst2;
				end

			aux_pkg::st_tst2 :
				if (!tst)
				begin
					en_clr = 1'b1;
					tx_clr = 1'b1;
					st_nxt = aux_pkg::st_idle;
				end
				else if (beat_fe)
				begin
					tx_clr = 1'b1;
					st_nxt = aux_pkg::st_tst1;
				end

			default :
				st_nxt = aux_pkg::st_idle;
		endcase
	end

// Byte shifter, MSB first
	always_ff @ (posedge CLK_IN)
	begin
		if (shft_ld)
		begin
			shft <= fifo_dout[aux_pkg::BYTE_WIDTH-1:0];
			shft_cnt <= CNT_WIDTH'(aux_pkg::BYTE_WIDTH - 1);
		end
		else if (shft_nxt)
		begin
			shft <= {shft[aux_pkg::BYTE_WIDTH-2:0], 1'b0};
			shft_cnt <= shft_cnt - 1'b1;
		end
	end

	assign shft_out = shft[aux_pkg::BYTE_WIDTH-1];
	assign shft_end = (shft_cnt == '0);	// Last bit on the line

// Line output registers
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			aux_en <= 1'b0;
			aux_tx <= 1'b0;
		end
		else if (!run)
		begin
			aux_en <= 1'b0;
			aux_tx <= 1'b0;
		end
		else
		begin
			if (en_set)
				aux_en <= 1'b1;
			else if (en_clr)
				aux_en <= 1'b0;

			if (tx_set)
				aux_tx <= 1'b1;
			else if (tx_clr)
				aux_tx <= 1'b0;
		end
	end

	a_rd_de : assert property (@(posedge CLK_IN) disable iff (RST_IN) fifo_rd |-> fifo_de)
		else $error("aux_tx_encoder fifo_rd without data");

	// Line idles low outside a message
	a_tx_quiet : assert property (@(posedge CLK_IN) disable iff (RST_IN)
		(!aux_en && !(st_cur inside {aux_pkg::st_tst1, aux_pkg::st_tst2})) |-> !aux_tx)
		else $error("aux_tx_encoder line active while disabled");

endmodule

// File: src/aux_tx_top.sv
`timescale 1ns/10ps

module aux_tx_top
#(
	parameter FIFO_WORDS = 32		// TX FIFO depth, power of two
)
(
	input wire					CLK_IN,
	input wire					RST_IN,
	input aux_pkg::lb_adr_t				lb_adr,
	input wire					lb_wr,
	input wire					lb_rd,
	input wire [aux_pkg::LB_DAT_WIDTH-1:0]		lb_din,
	output logic [aux_pkg::LB_DAT_WIDTH-1:0]	lb_dout,
	output logic					lb_vld,
	input wire					BEAT_IN,
	output logic					AUX_EN_OUT,
	output logic					AUX_TX_OUT,
	output logic					IRQ_OUT
);

logic					run;
logic					msg_send;
logic					tst;
logic					msg_send_clr;
logic					msg_done_set;
logic					fifo_wr;
logic [aux_pkg::TX_WORD_WIDTH-1:0]	fifo_din;
logic					fifo_clr;
logic					fifo_rd;
logic [aux_pkg::TX_WORD_WIDTH-1:0]	fifo_dout;
logic					fifo_de;
logic					fifo_ep;
logic					fifo_fl;

	// Host registers
	aux_lb_regs REGS_INST
	(
		.CLK_IN		(CLK_IN),
		.RST_IN		(RST_IN),
		.lb_adr		(lb_adr),
		.lb_wr		(lb_wr),
		.lb_rd		(lb_rd),
		.lb_din		(lb_din),
		.lb_dout	(lb_dout),
		.lb_vld		(lb_vld),
		.run		(run),
		.msg_send	(msg_send),
		.tst		(tst),
		.msg_send_clr	(msg_send_clr),
		.msg_done_set	(msg_done_set),
		.fifo_ep	(fifo_ep),
		.fifo_fl	(fifo_fl),
		.fifo_wr	(fifo_wr),
		.fifo_din	(fifo_din),
		.fifo_clr	(fifo_clr),
		.irq		(IRQ_OUT)
	);

	aux_fifo #(.FIFO_WORDS (FIFO_WORDS)) TX_FIFO_INST
	(
		.CLK_IN		(CLK_IN),
		.RST_IN		(RST_IN),
		.clr		(fifo_clr),
		.wr		(fifo_wr),
		.din		(fifo_din),
		.rd		(fifo_rd),
		.dout		(fifo_dout),
		.de		(fifo_de),
		.wrds		(),		// No status bit for it
		.ep		(fifo_ep),
		.fl		(fifo_fl)
	);

	// Manchester line driver
	aux_tx_encoder TX_ENC_INST
	(
		.CLK_IN		(CLK_IN),
		.RST_IN		(RST_IN),
		.BEAT_IN	(BEAT_IN),
		.run		(run),
		.msg_send	(msg_send),
		.tst		(tst),
		.fifo_dout	(fifo_dout),
		.fifo_de	(fifo_de),
		.fifo_ep	(fifo_ep),
		.fifo_rd	(fifo_rd),
		.msg_send_clr	(msg_send_clr),
		.msg_done_set	(msg_done_set),
		.aux_en		(AUX_EN_OUT),
		.aux_tx		(AUX_TX_OUT)
	);

endmodule

// File: testbench/aux_tx_checker.sv
`timescale 1ns/10ps

module aux_tx_checker
#(
	parameter MAX_W = 16
)
(
	input wire				CLK_IN,
	input wire				RST_IN,
	input wire				BEAT_IN,
	input wire				AUX_EN_OUT,
	input wire				AUX_TX_OUT,
	input wire				IRQ_OUT,
	input wire				lb_rd,
	input wire				lb_vld,
	input aux_pkg::lb_adr_t			lb_adr,
	input wire [31:0]			lb_dout,
	input wire [1:0]			mode,		// 0 off, 1 message, 2 test mode
	input wire [MAX_W-1:0][8:0]		exp_words,
	input int				exp_cnt,
	input wire				exp_quiet,	// Line must be idle
	input wire				irq_chk,	// IRQ_OUT compared while set
	input wire				exp_irq,
	input wire				rd_chk,
	input wire [31:0]			rd_exp,
	input wire				test_end,
	input int				test_id,
	output int				err_cnt
);

int				errs = 0;
int				test_base = 0;
bit				samples [$];	// Half-bits seen on the line
logic				rd_prev = 1'b0;
logic				rd_chk_q = 1'b0;
logic [31:0]			rd_exp_q;
aux_pkg::lb_adr_t		adr_q;
logic				en_prev = 1'b0;
logic				seen_re = 1'b0;

	assign err_cnt = errs;

task report(input string name, input logic [31:0] exp, input logic [31:0] got);
	$display("CHECK FAILED at %0t: %s expected %0h observed %0h", $time, name, exp, got);
	errs = errs + 1;
endtask

// Expected half-bit stream built from the FIFO entries
task automatic compare_stream;
	bit		exp_s [$];
	logic [8:0]	w;
	int		i;
	exp_s.push_back(1'b0);		// Idle half before the first bit
	for (i = 0; i < exp_cnt; i++)
	begin
		w = exp_words[i];
		if (w[8])
		begin
			repeat (4) exp_s.push_back(1'b1);	// Stop token, high then low
			repeat (4) exp_s.push_back(1'b0);
		end
		else
			for (int b = 7; b >= 0; b--)
			begin
				exp_s.push_back(w[b]);		// MSB first, bit then inverse
				exp_s.push_back(!w[b]);
			end
	end
	if (exp_s.size() != samples.size())
		report("AUX_TX_OUT half-bit count", exp_s.size(), samples.size());
	else
		for (i = 0; i < exp_s.size(); i++)
			if (exp_s[i] != samples[i])
			begin
				report($sformatf("AUX_TX_OUT half-bit %0d", i), exp_s[i], samples[i]);
				break;		// First mismatch is enough
			end
	samples.delete();
endtask

	// Line sampled at each beat edge, holds the previous half
	always @ (BEAT_IN)
	begin
		if (!RST_IN)
		begin
			if (mode == 2'd1 && AUX_EN_OUT)
				samples.push_back(AUX_TX_OUT);
			if (mode == 2'd2)
			begin
				if (AUX_EN_OUT !== 1'b1)
					report("AUX_EN_OUT", 1, AUX_EN_OUT);
				if (BEAT_IN)
				begin
					if (AUX_TX_OUT !== 1'b0)	// Half just ended was low
						report("AUX_TX_OUT", 0, AUX_TX_OUT);
					seen_re = 1'b1;
				end
				else if (seen_re && AUX_TX_OUT !== 1'b1)
					report("AUX_TX_OUT", 1, AUX_TX_OUT);
			end
			else
				seen_re = 1'b0;
		end
	end

	always @ (posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			rd_prev = 1'b0;
			rd_chk_q = 1'b0;
			en_prev = 1'b0;
		end
		else
		begin
			if (lb_vld !== rd_prev)		// Exactly one clock after the read
				report("lb_vld", rd_prev, lb_vld);
			if (rd_chk_q && lb_dout !== rd_exp_q)
				report($sformatf("lb_dout at address %0d", adr_q), rd_exp_q, lb_dout);
			rd_prev = lb_rd;
			rd_chk_q = rd_chk;
			rd_exp_q = rd_exp;
			adr_q = lb_adr;

			if (exp_quiet)
			begin
				if (AUX_EN_OUT !== 1'b0)
					report("AUX_EN_OUT", 0, AUX_EN_OUT);
				if (AUX_TX_OUT !== 1'b0)
					report("AUX_TX_OUT", 0, AUX_TX_OUT);
				if (IRQ_OUT !== 1'b0)
					report("IRQ_OUT", 0, IRQ_OUT);
			end

			if (irq_chk && IRQ_OUT !== exp_irq)
				report("IRQ_OUT", exp_irq, IRQ_OUT);

			if (mode == 2'd1 && en_prev && !AUX_EN_OUT)
				compare_stream();	// Enable fell, message over
			if (mode == 2'd0)
				samples.delete();
			en_prev = AUX_EN_OUT;

			if (test_end)
			begin
				if (errs == test_base)
					$display("Test %0d passed", test_id);
				else
					$display("Test %0d failed with %0d errors", test_id, errs - test_base);
				test_base = errs;
			end
		end
	end

endmodule

// File: testbench/tb_aux_tx.sv
`timescale 1ns/10ps

module tb_aux_tx;

localparam DEPTH = 8;			// Small FIFO keeps the full test short
localparam SEED = 41117;
localparam BEAT_HALF = 8;		// Clocks per beat half-period
localparam N_ROWS = 7;
localparam MAX_W = 16;
localparam K_RESET = 0, K_MSG = 1, K_IRQ = 2, K_FULL = 3, K_TST = 4, K_ABORT = 5;

logic					CLK_IN = 1'b0;
logic					RST_IN;
aux_pkg::lb_adr_t			lb_adr;
logic					lb_wr;
logic					lb_rd;
logic [31:0]				lb_din;
logic [31:0]				lb_dout;
logic					lb_vld;
logic					BEAT_IN;
logic					AUX_EN_OUT;
logic					AUX_TX_OUT;
logic					IRQ_OUT;
logic [1:0]				chk_mode;	// 0 off, 1 message, 2 test mode
logic [MAX_W-1:0][8:0]			exp_words;
int					exp_cnt;
logic					exp_quiet;
logic					irq_chk;
logic					exp_irq;
logic					rd_chk;
logic [31:0]				rd_exp;
logic					test_end;
int					test_id;
int					err_cnt;
int					beat_cnt = 0;
int					cycles = 0;
int					limit;
int					n_fail = 0;
int					err_base;
logic [8:0]				words [MAX_W];

// Stimulus table, one row per test
int		row_kind [N_ROWS] = '{K_RESET, K_MSG, K_IRQ, K_IRQ, K_FULL, K_TST, K_ABORT};
int		row_words [N_ROWS] = '{0, 6, 4, 4, DEPTH + 2, 0, 6};
bit		row_tok [N_ROWS] = '{0, 1, 1, 1, 0, 0, 1};	// Last entry is a stop token
logic [4:0]	row_ctl [N_ROWS] = '{5'h00, 5'h01, 5'h03, 5'h01, 5'h01, 5'h11, 5'h01};
logic [15:0]	row_sta [N_ROWS] = '{16'h0020, 16'h0022, 16'h0023, 16'h0022,
				16'h0022, 16'h0020, 16'h0020};	// Status after the test

	aux_tx_top #(.FIFO_WORDS (DEPTH)) UUT
	(
		.CLK_IN		(CLK_IN),
		.RST_IN		(RST_IN),
		.lb_adr		(lb_adr),
		.lb_wr		(lb_wr),
		.lb_rd		(lb_rd),
		.lb_din		(lb_din),
		.lb_dout	(lb_dout),
		.lb_vld		(lb_vld),
		.BEAT_IN	(BEAT_IN),
		.AUX_EN_OUT	(AUX_EN_OUT),
		.AUX_TX_OUT	(AUX_TX_OUT),
		.IRQ_OUT	(IRQ_OUT)
	);

	aux_tx_checker #(.MAX_W (MAX_W)) CHK
	(
		.CLK_IN (CLK_IN), .RST_IN (RST_IN), .BEAT_IN (BEAT_IN),
		.AUX_EN_OUT (AUX_EN_OUT), .AUX_TX_OUT (AUX_TX_OUT), .IRQ_OUT (IRQ_OUT),
		.lb_rd (lb_rd), .lb_vld (lb_vld), .lb_adr (lb_adr), .lb_dout (lb_dout),
		.mode (chk_mode), .exp_words (exp_words), .exp_cnt (exp_cnt),
		.exp_quiet (exp_quiet), .irq_chk (irq_chk), .exp_irq (exp_irq),
		.rd_chk (rd_chk), .rd_exp (rd_exp),
		.test_end (test_end), .test_id (test_id), .err_cnt (err_cnt)
	);

	always #4 CLK_IN = ~CLK_IN;	// 8 ns period

	// Beat square wave, changes on the falling clock edge
	always @ (negedge CLK_IN)
	begin
		beat_cnt = beat_cnt + 1;
		if (beat_cnt == BEAT_HALF)
		begin
			BEAT_IN <= ~BEAT_IN;
			beat_cnt = 0;
		end
	end

	// Run limit
	always @ (posedge CLK_IN)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("Timeout after %0d clocks, the DUT stopped responding", cycles);
			$display("Regression failed");
			$finish;
		end
	end

task wait_clocks(input int n);
	repeat (n) @ (negedge CLK_IN);
endtask

task bus_write(input aux_pkg::lb_adr_t adr, input logic [31:0] data);
	@ (negedge CLK_IN);
	lb_adr = adr;
	lb_din = data;
	lb_wr = 1'b1;
	@ (negedge CLK_IN);
	lb_wr = 1'b0;
endtask

// Read with the expected value handed to the checker
task bus_read(input aux_pkg::lb_adr_t adr, input logic [31:0] exp);
	@ (negedge CLK_IN);
	lb_adr = adr;
	lb_rd = 1'b1;
	rd_chk = 1'b1;
	rd_exp = exp;
	@ (negedge CLK_IN);
	lb_rd = 1'b0;
	rd_chk = 1'b0;
	@ (negedge CLK_IN);
endtask

task load_fifo(input int n);
	for (int i = 0; i < n; i++)
		bus_write(aux_pkg::adr_tx_fifo, {23'd0, words[i]});
endtask

task wait_message;
	while (AUX_EN_OUT !== 1'b1)
		@ (negedge CLK_IN);
	while (AUX_EN_OUT !== 1'b0)
		@ (negedge CLK_IN);
endtask

	initial
	begin
		void'($urandom(SEED));
		RST_IN = 1'b1;
		lb_adr = aux_pkg::adr_ctl;
		lb_wr = 1'b0;
		lb_rd = 1'b0;
		lb_din = '0;
		BEAT_IN = 1'b0;
		chk_mode = 2'd0;
		exp_words = '0;
		exp_cnt = 0;
		exp_quiet = 1'b0;
		irq_chk = 1'b0;
		exp_irq = 1'b0;
		rd_chk = 1'b0;
		rd_exp = '0;
		test_end = 1'b0;
		test_id = 0;
		limit = 2000;
		for (int r = 0; r < N_ROWS; r++)
			limit = limit + 2 * (row_words[r] * 8 + 10) * 2 * BEAT_HALF;
		repeat (8) @ (posedge CLK_IN);
		@ (negedge CLK_IN);
		RST_IN = 1'b0;

		for (int r = 0; r < N_ROWS; r++)
		begin
			test_id = r;
			err_base = err_cnt;
			// The IE clear row resends the message of the row before it
			if (!(r > 0 && row_kind[r] == K_IRQ && row_kind[r-1] == K_IRQ))
				for (int i = 0; i < MAX_W; i++)
				begin
					words[i] = {1'b0, 8'($urandom & 32'hff)};
					if (row_tok[r] && i == row_words[r] - 1)
						words[i][8] = 1'b1;	// Stop token
					exp_words[i] = words[i];
				end
			exp_cnt = (row_kind[r] == K_FULL) ? DEPTH : row_words[r];	// Extras dropped

			case (row_kind[r])
				K_RESET :
				begin
					exp_quiet = 1'b1;
					bus_read(aux_pkg::adr_sta, {16'd0, row_sta[r]});
					bus_read(aux_pkg::adr_rx_fifo, 32'hdeadcafe);
					bus_read(aux_pkg::adr_tx_fifo, 32'hdeadcafe);
					bus_read(aux_pkg::adr_ctl, 32'd0);
					exp_quiet = 1'b0;
				end
				K_MSG, K_IRQ, K_FULL :
				begin
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r]});
					load_fifo(row_words[r]);
					if (row_kind[r] == K_FULL)
						bus_read(aux_pkg::adr_sta, 32'h0040);	// Full, not empty
					chk_mode = 2'd1;
					exp_irq = 1'b0;		// Low until the message is done
					irq_chk = 1'b1;
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r] | 5'h04});
					wait_message();
					exp_irq = row_ctl[r][aux_pkg::CTL_IE];	// Rises with enable fall
					wait_clocks(4);
					chk_mode = 2'd0;
					bus_read(aux_pkg::adr_sta, {16'd0, row_sta[r]});
					bus_read(aux_pkg::adr_ctl, {27'd0, row_ctl[r]});	// Send bit cleared
					if (row_kind[r] == K_IRQ)
					begin
						bus_write(aux_pkg::adr_sta, 32'h0001);
						wait_clocks(1);
						exp_irq = 1'b0;
						bus_read(aux_pkg::adr_sta, {16'd0, row_sta[r] & 16'hfffe});
					end
					irq_chk = 1'b0;
				end
				K_TST :
				begin
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r]});
					wait_clocks(4);
					chk_mode = 2'd2;
					wait_clocks(12 * BEAT_HALF);
					chk_mode = 2'd0;
					bus_read(aux_pkg::adr_sta, {16'd0, row_sta[r]});
				end
				default :
				begin
					// Abort mid-message
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r]});
					load_fifo(row_words[r]);
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r] | 5'h04});
					while (AUX_EN_OUT !== 1'b1)
						@ (negedge CLK_IN);
					wait_clocks(10 * BEAT_HALF);
					bus_write(aux_pkg::adr_ctl, 32'd0);
					wait_clocks(3);
					exp_quiet = 1'b1;
					wait_clocks(4 * BEAT_HALF);
					exp_quiet = 1'b0;
					bus_write(aux_pkg::adr_ctl, {27'd0, row_ctl[r]});
					bus_read(aux_pkg::adr_sta, {16'd0, row_sta[r]});
				end
			endcase

			bus_write(aux_pkg::adr_ctl, 32'd0);	// Stop, flush flags and FIFO
			wait_clocks(4);
			if (err_cnt != err_base)
				n_fail = n_fail + 1;
			test_end = 1'b1;
			@ (negedge CLK_IN);
			test_end = 1'b0;
		end

		wait_clocks(2);
		$display("Tests %0d, failed %0d, errors %0d", N_ROWS, n_fail, err_cnt);
		if (err_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
